// ==== Makefile ====
SOURCES := $(wildcard include/*.svh source/*.sv verif/*.sv)

all: run

obj_dir/Vrace_tb: project.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module race_tb -o Vrace_tb

run: obj_dir/Vrace_tb
	./obj_dir/Vrace_tb | tee sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// ==== include/race_settings.svh ====
`ifndef RACE_SETTINGS_SVH
`define RACE_SETTINGS_SVH

// signed speed width, wide enough for the limit plus one acceleration step
`define RACE_VEL_W 10

// speed saturates at plus or minus this magnitude
`define RACE_VEL_MAX 300

// multiplier on the 3-bit signed acceleration switch value
`define RACE_ACC_SCALE 2

// heading is unsigned and wraps
`define RACE_ANG_W 8

// heading change per frame while steering
`define RACE_OMEGA_STEP 4

`endif

// ==== project.f ====
+incdir+include
source/race_pkg.sv
source/control_decoder.sv
source/car_dynamics.sv
source/speed_display.sv
source/race_core.sv
verif/race_props.sv
verif/race_checker.sv
verif/race_tb.sv

// ==== source/car_dynamics.sv ====
`timescale 1ns/1ps

`include "race_settings.svh"

module car_dynamics (
	input  logic                          i_clk,
	input  logic                          i_reset,
	input  logic                          i_cmd_valid,
	input  race_pkg::car_cmd_t            i_cmd,
	output logic signed [`RACE_VEL_W-1:0] o_vel,
	output logic [`RACE_ANG_W-1:0]        o_heading,
	output logic                          o_update
);

	// one extra bit of headroom for the sum before saturation
	logic signed [`RACE_VEL_W:0] vel_ext;
	logic signed [`RACE_VEL_W:0] acc_ext;
	logic signed [`RACE_VEL_W:0] acc_term;
	logic signed [`RACE_VEL_W:0] vel_sum;
	logic signed [`RACE_VEL_W:0] vel_next;
	logic [`RACE_ANG_W-1:0]      heading_next;

	// speed update
	always_comb begin
		vel_ext  = o_vel;
		acc_ext  = {{(`RACE_VEL_W-2){i_cmd.acc[2]}}, i_cmd.acc};
		acc_term = acc_ext * `RACE_ACC_SCALE;
		vel_sum  = vel_ext + acc_term;

		if (i_cmd.acc != 3'd0) begin
			if (vel_sum > `RACE_VEL_MAX) begin
				vel_next = `RACE_VEL_MAX;
			end else if (vel_sum < -`RACE_VEL_MAX) begin
				vel_next = -`RACE_VEL_MAX;
			end else begin
				vel_next = vel_sum;
			end
		end else begin
			// drag, one step toward zero
			if (vel_ext > 0) begin
				vel_next = vel_ext - 1;
			end else if (vel_ext < 0) begin
				vel_next = vel_ext + 1;
			end else begin
				vel_next = vel_ext;
			end
		end
	end

	// heading wraps modulo 2^ANG_W
	always_comb begin
		heading_next = o_heading;
		case (i_cmd.steer)
			race_pkg::STEER_LEFT:  heading_next = o_heading + `RACE_OMEGA_STEP;
			race_pkg::STEER_RIGHT: heading_next = o_heading - `RACE_OMEGA_STEP;
			race_pkg::STEER_NONE:  heading_next = o_heading;
			race_pkg::STEER_HOLD:  heading_next = o_heading;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_vel     <= '0;
			o_heading <= '0;
			o_update  <= 1'b0;
		end else begin
			o_update <= i_cmd_valid;
			if (i_cmd_valid) begin
				o_vel     <= vel_next[`RACE_VEL_W-1:0];
				o_heading <= heading_next;
			end
		end
	end

endmodule

// ==== source/control_decoder.sv ====
`timescale 1ns/1ps

module control_decoder (
	input  logic                i_clk,
	input  logic                i_reset,
	input  logic [17:0]         i_sw,
	input  logic                i_frame_tick,
	output logic                o_cmd_valid,
	output race_pkg::car_cmd_t  o_car1_cmd,
	output race_pkg::car_cmd_t  o_car2_cmd
);

	race_pkg::car_cmd_t car1_fields;
	race_pkg::car_cmd_t car2_fields;

	// switch layout follows the board
	// car 1 on the low switches, car 2 on the high ones
	always_comb begin
		car1_fields.acc   = i_sw[2:0];
		car1_fields.steer = race_pkg::steer_e'(i_sw[4:3]);
		car2_fields.acc   = i_sw[15:13];
		car2_fields.steer = race_pkg::steer_e'(i_sw[17:16]);
	end

	// one strobe per frame tick
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_cmd_valid <= 1'b0;
		end else begin
			o_cmd_valid <= i_frame_tick;
		end
	end

	// both commands captured from the same sampled cycle
	always_ff @(posedge i_clk) begin
		if (i_frame_tick) begin
			o_car1_cmd <= car1_fields;
			o_car2_cmd <= car2_fields;
		end
	end

endmodule

// ==== source/race_core.sv ====
`timescale 1ns/1ps

`include "race_settings.svh"

module race_core (
	input  logic                          i_clk,
	input  logic                          i_reset,
	input  logic [17:0]                   i_sw,
	input  logic                          i_frame_tick,
	output logic                          o_update,
	output logic signed [`RACE_VEL_W-1:0] o_car1_vel,
	output logic signed [`RACE_VEL_W-1:0] o_car2_vel,
	output logic [`RACE_ANG_W-1:0]        o_car1_heading,
	output logic [`RACE_ANG_W-1:0]        o_car2_heading,
	output race_pkg::seg_digits_t         o_car1_digits,
	output race_pkg::seg_digits_t         o_car2_digits
);

	logic               cmd_valid;
	race_pkg::car_cmd_t car1_cmd;
	race_pkg::car_cmd_t car2_cmd;

	control_decoder u_decoder (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_sw         (i_sw),
		.i_frame_tick (i_frame_tick),
		.o_cmd_valid  (cmd_valid),
		.o_car1_cmd   (car1_cmd),
		.o_car2_cmd   (car2_cmd)
	);

	car_dynamics car1 (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_cmd_valid (cmd_valid),
		.i_cmd       (car1_cmd),
		.o_vel       (o_car1_vel),
		.o_heading   (o_car1_heading),
		.o_update    (o_update)
	);

	// both cars step together, so car 1 alone drives o_update
	car_dynamics car2 (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_cmd_valid (cmd_valid),
		.i_cmd       (car2_cmd),
		.o_vel       (o_car2_vel),
		.o_heading   (o_car2_heading),
		.o_update    ()
	);

	speed_display u_car1_display (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_vel    (o_car1_vel),
		.o_digits (o_car1_digits)
	);

	speed_display u_car2_display (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_vel    (o_car2_vel),
		.o_digits (o_car2_digits)
	);

endmodule

// ==== source/race_pkg.sv ====
package race_pkg;

	// steering switch encoding
	typedef enum logic [1:0] {
		STEER_NONE  = 2'd0,
		// raises the heading
		STEER_LEFT  = 2'd1,
		// lowers the heading
		STEER_RIGHT = 2'd2,
		// same effect as none
		STEER_HOLD  = 2'd3
	} steer_e;

	// one car's command for a single frame
	typedef struct packed {
		logic signed [2:0] acc;
		steer_e            steer;
	} car_cmd_t;

	// active-low patterns in {g..a} order, 0 lights a segment
	typedef struct packed {
		logic [6:0] sign;
		logic [6:0] hundred;
		logic [6:0] ten;
		logic [6:0] one;
	} seg_digits_t;

endpackage

// ==== source/speed_display.sv ====
`timescale 1ns/1ps

`include "race_settings.svh"

module speed_display (
	input  logic                          i_clk,
	input  logic                          i_reset,
	input  logic signed [`RACE_VEL_W-1:0] i_vel,
	output race_pkg::seg_digits_t         o_digits
);

	// hex decoder patterns, active low, {g..a}
	localparam logic [6:0] SEG_HEX [0:15] = '{
		7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
		7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
		7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
		7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
	};

	// only segment g lit
	localparam logic [6:0] SEG_DASH  = 7'b0111111;
	localparam logic [6:0] SEG_BLANK = 7'b1111111;

	logic [`RACE_VEL_W-1:0] mag;
	logic [3:0]             hundred;
	logic [3:0]             ten;
	logic [3:0]             one;
	race_pkg::seg_digits_t  digits_next;

	// magnitude is at most 300, so hundreds never exceeds 3
	always_comb begin
		if (i_vel[`RACE_VEL_W-1]) begin
			mag = -i_vel;
		end else begin
			mag = i_vel;
		end
		hundred = 4'(mag / 100);
		ten     = 4'((mag / 10) % 10);
		one     = 4'(mag % 10);
	end

	always_comb begin
		digits_next.sign    = i_vel[`RACE_VEL_W-1] ? SEG_DASH : SEG_BLANK;
		digits_next.hundred = SEG_HEX[hundred];
		digits_next.ten     = SEG_HEX[ten];
		digits_next.one     = SEG_HEX[one];
	end

	// blank sign and "000" out of reset
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_digits.sign    <= SEG_BLANK;
			o_digits.hundred <= SEG_HEX[0];
			o_digits.ten     <= SEG_HEX[0];
			o_digits.one     <= SEG_HEX[0];
		end else begin
			o_digits <= digits_next;
		end
	end

endmodule

// ==== verif/race_checker.sv ====
`timescale 1ns/1ps

`include "race_settings.svh"

module race_checker (
	input  logic                          i_clk,
	input  logic                          i_reset,
	input  logic [17:0]                   i_sw,
	input  logic                          i_frame_tick,
	input  logic                          i_update,
	input  logic signed [`RACE_VEL_W-1:0] i_car1_vel,
	input  logic signed [`RACE_VEL_W-1:0] i_car2_vel,
	input  logic [`RACE_ANG_W-1:0]        i_car1_heading,
	input  logic [`RACE_ANG_W-1:0]        i_car2_heading,
	input  race_pkg::seg_digits_t         i_car1_digits,
	input  race_pkg::seg_digits_t         i_car2_digits,
	input  logic [2:0]                    i_test_num,
	input  logic                          i_test_end,
	output int                            o_errors
);

	localparam int HEAD_MOD = 1 << `RACE_ANG_W;

	// decimal digits, active low, {g..a}
	localparam logic [6:0] DIGIT_SEGS [0:9] = '{
		7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001,
		7'b0010010, 7'b0000010, 7'b1111000, 7'b0000000, 7'b0010000
	};

	// modelled registers, index 0 is car 1
	logic                  m_valid;
	logic                  m_update;
	race_pkg::car_cmd_t    m_cmd [2];
	int                    m_vel [2];
	int                    m_head [2];
	race_pkg::seg_digits_t m_digits [2];

	int checks = 0;
	int test_errors = 0;
	int digit_checks = 0;
	int digit_errors = 0;
	int total_checks = 0;
	int last_head = 0;
	bit seen_max = 1'b0;
	bit seen_min = 1'b0;
	bit wrap_up = 1'b0;
	bit wrap_down = 1'b0;

	initial o_errors = 0;

	function automatic int vel_after(input int vel, input logic signed [2:0] acc);
		int v;
		v = vel;
		if (acc != 0) begin
			v = vel + int'(acc) * `RACE_ACC_SCALE;
			if (v > `RACE_VEL_MAX) v = `RACE_VEL_MAX;
			if (v < -`RACE_VEL_MAX) v = -`RACE_VEL_MAX;
		end else if (vel > 0) begin
			v = vel - 1;
		end else if (vel < 0) begin
			v = vel + 1;
		end
		return v;
	endfunction

	function automatic int heading_after(input int head, input race_pkg::steer_e steer);
		int step;
		step = 0;
		if (steer == race_pkg::STEER_LEFT) step = `RACE_OMEGA_STEP;
		if (steer == race_pkg::STEER_RIGHT) step = -`RACE_OMEGA_STEP;
		return (head + step + HEAD_MOD) % HEAD_MOD;
	endfunction

	function automatic race_pkg::seg_digits_t digits_for(input int vel);
		race_pkg::seg_digits_t d;
		int mag;
		mag = (vel < 0) ? -vel : vel;
		// dash for negative speed, blank otherwise
		d.sign    = (vel < 0) ? 7'b0111111 : 7'b1111111;
		d.hundred = DIGIT_SEGS[mag / 100];
		d.ten     = DIGIT_SEGS[(mag / 10) % 10];
		d.one     = DIGIT_SEGS[mag % 10];
		return d;
	endfunction

	function automatic string test_name(input int n);
		case (n)
			1: return "reset values";
			2: return "random frames";
			3: return "saturation";
			4: return "drag to zero";
			5: return "heading wrap";
			default: return "display digits";
		endcase
	endfunction

	task automatic check(input string what, input int got, input int want, input bit digit);
		total_checks++;
		if (digit) digit_checks++;
		else checks++;
		if (got != want) begin
			$display("ERROR %0t: %s is %0d, model expects %0d", $time, what, got, want);
			o_errors++;
			if (digit) digit_errors++;
			else test_errors++;
		end
	endtask

	task automatic fail_goal(input string why);
		$display("test %0d went wrong: %s", i_test_num, why);
		o_errors++;
		test_errors++;
	endtask

	task automatic report_test();
		case (i_test_num)
			3'd3: if (!(seen_max && seen_min)) fail_goal("speed never held at both limits");
			3'd4: if (i_car1_vel != 0 || i_car2_vel != 0) fail_goal("speed did not settle at zero");
			3'd5: if (!(wrap_up && wrap_down)) fail_goal("heading did not wrap both ways");
			default: ;
		endcase
		if (i_test_num == 3'd6) begin
			$display("test 6 (%s): %0d checks, %0d errors", test_name(6), digit_checks, digit_errors);
			$display("totals: %0d checks, %0d errors", total_checks, o_errors);
		end else begin
			$display("test %0d (%s): %0d checks, %0d errors", i_test_num,
				test_name(i_test_num), checks, test_errors);
		end
		checks = 0;
		test_errors = 0;
		seen_max = 1'b0;
		seen_min = 1'b0;
		wrap_up = 1'b0;
		wrap_down = 1'b0;
	endtask

	// outputs sampled before the edge, model then steps one cycle
	always @(posedge i_clk) begin
		if (i_reset) begin
			m_valid = 1'b0;
			m_update = 1'b0;
			for (int c = 0; c < 2; c++) begin
				m_vel[c] = 0;
				m_head[c] = 0;
				m_digits[c] = digits_for(0);
			end
		end else begin
			check("o_update", i_update, m_update, 1'b0);
			check("car 1 speed", i_car1_vel, m_vel[0], 1'b0);
			check("car 2 speed", i_car2_vel, m_vel[1], 1'b0);
			check("car 1 heading", i_car1_heading, m_head[0], 1'b0);
			check("car 2 heading", i_car2_heading, m_head[1], 1'b0);
			check("car 1 digits", i_car1_digits, m_digits[0], 1'b1);
			check("car 2 digits", i_car2_digits, m_digits[1], 1'b1);

			if (i_car1_vel == `RACE_VEL_MAX && i_car2_vel == `RACE_VEL_MAX) seen_max = 1'b1;
			if (i_car1_vel == -`RACE_VEL_MAX && i_car2_vel == -`RACE_VEL_MAX) seen_min = 1'b1;
			if (last_head >= HEAD_MOD - `RACE_OMEGA_STEP && i_car1_heading < `RACE_OMEGA_STEP)
				wrap_up = 1'b1;
			if (last_head < `RACE_OMEGA_STEP && i_car1_heading >= HEAD_MOD - `RACE_OMEGA_STEP)
				wrap_down = 1'b1;
			last_head = i_car1_heading;

			// display lags the speed by one register
			for (int c = 0; c < 2; c++) begin
				m_digits[c] = digits_for(m_vel[c]);
				if (m_valid) begin
					m_vel[c] = vel_after(m_vel[c], m_cmd[c].acc);
					m_head[c] = heading_after(m_head[c], m_cmd[c].steer);
				end
			end
			m_update = m_valid;
			m_valid = i_frame_tick;
			if (i_frame_tick) begin
				m_cmd[0].acc = i_sw[2:0];
				m_cmd[0].steer = race_pkg::steer_e'(i_sw[4:3]);
				m_cmd[1].acc = i_sw[15:13];
				m_cmd[1].steer = race_pkg::steer_e'(i_sw[17:16]);
			end
		end
		if (i_test_end) report_test();
	end

endmodule

// ==== verif/race_props.sv ====
`timescale 1ns/1ps

`include "race_settings.svh"

module race_props (
	input logic                          i_clk,
	input logic                          i_reset,
	input logic                          i_cmd_valid,
	input logic                          i_update,
	input logic signed [`RACE_VEL_W-1:0] i_car1_vel,
	input logic signed [`RACE_VEL_W-1:0] i_car2_vel,
	input logic [`RACE_ANG_W-1:0]        i_car1_heading,
	input logic [`RACE_ANG_W-1:0]        i_car2_heading
);

	// update strobe is the command strobe one cycle later
	update_follows_cmd: assert property (@(posedge i_clk) disable iff (i_reset)
		i_cmd_valid |=> i_update)
		else $error("update strobe missing one cycle after the command strobe");

	no_cmd_no_update: assert property (@(posedge i_clk) disable iff (i_reset)
		!i_cmd_valid |=> !i_update)
		else $error("update strobe raised without a command strobe");

	speed_in_range: assert property (@(posedge i_clk) disable iff (i_reset)
		(i_car1_vel <= `RACE_VEL_MAX) && (i_car1_vel >= -`RACE_VEL_MAX) &&
		(i_car2_vel <= `RACE_VEL_MAX) && (i_car2_vel >= -`RACE_VEL_MAX))
		else $error("speed outside the allowed range");

	// state only moves on a command strobe
	hold_without_cmd: assert property (@(posedge i_clk) disable iff (i_reset)
		!i_cmd_valid |=> $stable(i_car1_vel) && $stable(i_car2_vel) &&
		$stable(i_car1_heading) && $stable(i_car2_heading))
		else $error("speed or heading changed without a command strobe");

endmodule

bind race_core race_props u_props (
	.i_clk          (i_clk),
	.i_reset        (i_reset),
	.i_cmd_valid    (cmd_valid),
	.i_update       (o_update),
	.i_car1_vel     (o_car1_vel),
	.i_car2_vel     (o_car2_vel),
	.i_car1_heading (o_car1_heading),
	.i_car2_heading (o_car2_heading)
);

// ==== verif/race_tb.sv ====
`timescale 1ns/1ps

`include "race_settings.svh"

module race_tb;

	// frames over all tests, each up to 4 cycles long
	localparam int FRAME_COUNT = 980;
	localparam int TIMEOUT_CYCLES = 2 * (FRAME_COUNT * 4 + 100);

	localparam logic [2:0] ACC_ZERO = 3'b000;
	localparam logic [2:0] ACC_UP = 3'b011;
	localparam logic [2:0] ACC_DOWN = 3'b100;

	logic                          clk;
	logic                          reset;
	logic [17:0]                   sw;
	logic                          tick;
	logic                          update;
	logic signed [`RACE_VEL_W-1:0] car1_vel;
	logic signed [`RACE_VEL_W-1:0] car2_vel;
	logic [`RACE_ANG_W-1:0]        car1_heading;
	logic [`RACE_ANG_W-1:0]        car2_heading;
	race_pkg::seg_digits_t         car1_digits;
	race_pkg::seg_digits_t         car2_digits;
	logic [2:0]                    test_num;
	logic                          test_end;
	logic [31:0]                   lfsr;
	int                            errors;
	int                            cycles = 0;

	race_core uut (
		.i_clk          (clk),
		.i_reset        (reset),
		.i_sw           (sw),
		.i_frame_tick   (tick),
		.o_update       (update),
		.o_car1_vel     (car1_vel),
		.o_car2_vel     (car2_vel),
		.o_car1_heading (car1_heading),
		.o_car2_heading (car2_heading),
		.o_car1_digits  (car1_digits),
		.o_car2_digits  (car2_digits)
	);

	race_checker u_checker (
		.i_clk          (clk),
		.i_reset        (reset),
		.i_sw           (sw),
		.i_frame_tick   (tick),
		.i_update       (update),
		.i_car1_vel     (car1_vel),
		.i_car2_vel     (car2_vel),
		.i_car1_heading (car1_heading),
		.i_car2_heading (car2_heading),
		.i_car1_digits  (car1_digits),
		.i_car2_digits  (car2_digits),
		.i_test_num     (test_num),
		.i_test_end     (test_end),
		.o_errors       (errors)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// one tick, then a random gap of 0 to 3 cycles
	task automatic drive_frame(input logic [2:0] acc1, input logic [1:0] steer1,
		input logic [2:0] acc2, input logic [1:0] steer2);
		logic [17:0] sw_val;
		logic [1:0]  gap;
		sw_val = 18'(random_bits(18));
		sw_val[2:0] = acc1;
		sw_val[4:3] = steer1;
		sw_val[15:13] = acc2;
		sw_val[17:16] = steer2;
		sw = sw_val;
		tick = 1'b1;
		@(negedge clk);
		tick = 1'b0;
		gap = 2'(random_bits(2));
		repeat (gap) @(negedge clk);
	endtask

	task automatic end_test();
		// let frames in flight reach the display
		repeat (3) @(negedge clk);
		test_end = 1'b1;
		@(negedge clk);
		test_end = 1'b0;
	endtask

	initial begin
		reset = 1'b1;
		sw = '0;
		tick = 1'b0;
		test_num = 3'd0;
		test_end = 1'b0;
		lfsr = 32'h92a0_f268;
		repeat (8) @(negedge clk);
		reset = 1'b0;

		test_num = 3'd1;
		repeat (4) @(negedge clk);
		end_test();

		test_num = 3'd2;
		repeat (300) drive_frame(3'(random_bits(3)), 2'(random_bits(2)),
			3'(random_bits(3)), 2'(random_bits(2)));
		end_test();

		test_num = 3'd3;
		repeat (200) drive_frame(ACC_UP, 2'(random_bits(2)), ACC_UP, 2'(random_bits(2)));
		repeat (200) drive_frame(ACC_DOWN, 2'(random_bits(2)), ACC_DOWN, 2'(random_bits(2)));
		end_test();

		// back off the negative limit, then coast
		test_num = 3'd4;
		repeat (40) drive_frame(ACC_UP, race_pkg::STEER_NONE, ACC_UP, race_pkg::STEER_NONE);
		repeat (90) drive_frame(ACC_ZERO, race_pkg::STEER_NONE, ACC_ZERO, race_pkg::STEER_NONE);
		end_test();

		test_num = 3'd5;
		repeat (70) drive_frame(3'(random_bits(3)), race_pkg::STEER_LEFT,
			3'(random_bits(3)), race_pkg::STEER_RIGHT);
		repeat (10) drive_frame(3'(random_bits(3)), race_pkg::STEER_HOLD,
			3'(random_bits(3)), race_pkg::STEER_HOLD);
		repeat (70) drive_frame(3'(random_bits(3)), race_pkg::STEER_RIGHT,
			3'(random_bits(3)), race_pkg::STEER_LEFT);
		end_test();

		test_num = 3'd6;
		end_test();

		@(negedge clk);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("run hung: still running after %0d cycles", cycles);
			$display("test failed");
			$finish;
		end
	end

endmodule
